/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int data_width = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [data_width-1:0] word_t;

    // primary opcodes, ir[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } op_t;

    // special function codes, ir[5:0]
    typedef enum logic [5:0] {
        fn_syscall = 6'h0c,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_slt     = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_writeback,
        st_halted
    } state_t;

    // branch flags arrive already qualified by the operand compare
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    write_rd;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    syscall;
    } ctrl_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire  mips_pkg::word_t   a,
    input  wire  mips_pkg::word_t   b,
    input  wire  mips_pkg::alu_op_t op,
    output mips_pkg::word_t         y
);

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: y = a + b;
            mips_pkg::alu_sub: y = a - b;
            mips_pkg::alu_and: y = a & b;
            mips_pkg::alu_or:  y = a | b;
            // signed compare
            mips_pkg::alu_slt: y = {{(mips_pkg::data_width-1){1'b0}}, less};
            default:           y = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                       clk,
    input  wire  mips_pkg::reg_addr_t raddr_a,
    input  wire  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t           rdata_a,
    output mips_pkg::word_t           rdata_b,
    input  wire                       we,
    input  wire  mips_pkg::reg_addr_t waddr,
    input  wire  mips_pkg::word_t     wdata,
    output mips_pkg::word_t           v0
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero never written, still masked on read
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // $v0 for the syscall check
    assign v0 = regs[2];

endmodule

`default_nettype wire

/* src/retire_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              retire,
    input  wire              halt,
    output mips_pkg::word_t  retired,
    output logic             halted
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired <= '0;
            halted  <= 1'b0;
        end else begin
            // the halting syscall retires in the same cycle it raises halt
            if (retire && !halted) begin
                retired <= retired + 1'b1;
            end
            if (halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mips_control.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_control (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  mips_pkg::word_t  ir,
    input  wire                    v0_is_ten,
    input  wire                    operands_equal,
    input  wire                    ack,
    output mips_pkg::ctrl_t        ctrl,
    output mips_pkg::state_t       state,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic                   retire,
    output logic                   halt
);

    mips_pkg::op_t    opcode;
    mips_pkg::funct_t funct;
    mips_pkg::state_t state_next;

    assign opcode = mips_pkg::op_t'(ir[31:26]);
    assign funct  = mips_pkg::funct_t'(ir[5:0]);

    // instruction decode, unknown encodings leave everything low
    always_comb begin
        ctrl = '0;
        ctrl.alu_op = mips_pkg::alu_add;
        case (opcode)
            mips_pkg::op_special: begin
                ctrl.write_rd  = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_syscall: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.syscall   = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            mips_pkg::op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_pkg::op_beq: ctrl.branch_eq = operands_equal;
            mips_pkg::op_bne: ctrl.branch_ne = !operands_equal;
            mips_pkg::op_j:   ctrl.jump = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::st_fetch:     if (ack) state_next = mips_pkg::st_decode;
            mips_pkg::st_decode:    state_next = mips_pkg::st_execute;
            mips_pkg::st_execute: begin
                if (ctrl.mem_read || ctrl.mem_write) state_next = mips_pkg::st_mem;
                else state_next = mips_pkg::st_writeback;
            end
            mips_pkg::st_mem:       if (ack) state_next = mips_pkg::st_writeback;
            mips_pkg::st_writeback: state_next = halt ? mips_pkg::st_halted : mips_pkg::st_fetch;
            default:                state_next = mips_pkg::st_halted;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= mips_pkg::st_fetch;
        else state <= state_next;
    end

    // bus strobes held until the ack cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 1'b0;
        end else begin
            cyc <= (state_next == mips_pkg::st_fetch) || (state_next == mips_pkg::st_mem);
        end
    end

    assign stb    = cyc;
    assign we     = (state == mips_pkg::st_mem) && ctrl.mem_write;
    assign retire = (state == mips_pkg::st_writeback);
    assign halt   = retire && ctrl.syscall && v0_is_ten;

endmodule

`default_nettype wire

/* src/mips_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_datapath #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  mips_pkg::state_t    state,
    input  wire  mips_pkg::ctrl_t     ctrl,
    input  wire  mips_pkg::word_t     bus_rdata,
    input  wire                       ack,
    input  wire  mips_pkg::word_t     rf_rdata_a,
    input  wire  mips_pkg::word_t     rf_rdata_b,
    input  wire  mips_pkg::word_t     v0,
    input  wire  mips_pkg::word_t     alu_result,
    output mips_pkg::word_t           ir,
    output mips_pkg::word_t           adr,
    output mips_pkg::word_t           dat,
    output mips_pkg::reg_addr_t       rf_raddr_a,
    output mips_pkg::reg_addr_t       rf_raddr_b,
    output logic                      rf_we,
    output mips_pkg::reg_addr_t       rf_waddr,
    output mips_pkg::word_t           rf_wdata,
    output mips_pkg::word_t           alu_a,
    output mips_pkg::word_t           alu_b,
    output mips_pkg::alu_op_t         alu_op,
    output logic                      v0_is_ten,
    output logic                      operands_equal
);

    mips_pkg::word_t pc, opa, opb, result, mdr;
    mips_pkg::word_t imm_ext, pc_plus4, pc_next;

    assign imm_ext  = {{(mips_pkg::data_width-16){ir[15]}}, ir[15:0]};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.jump) pc_next = {pc_plus4[31:28], ir[25:0], 2'b00};
        else if (ctrl.branch_eq || ctrl.branch_ne) pc_next = pc_plus4 + {imm_ext[29:0], 2'b00};
        else pc_next = pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
            ir <= '0;
        end else begin
            if ((state == mips_pkg::st_fetch) && ack) ir <= bus_rdata;
            if (state == mips_pkg::st_writeback) pc <= pc_next;
        end
    end

    // operand, result and load data registers
    always_ff @(posedge clk) begin
        if (state == mips_pkg::st_decode) begin
            opa <= rf_rdata_a;
            opb <= rf_rdata_b;
        end
        if (state == mips_pkg::st_execute) result <= alu_result;
        if ((state == mips_pkg::st_mem) && ack && ctrl.mem_read) mdr <= bus_rdata;
    end

    assign rf_raddr_a = ir[25:21];
    assign rf_raddr_b = ir[20:16];
    assign alu_a      = opa;
    assign alu_b      = ctrl.use_imm ? imm_ext : opb;
    assign alu_op     = ctrl.alu_op;

    assign rf_we    = (state == mips_pkg::st_writeback) && ctrl.reg_write;
    assign rf_waddr = ctrl.write_rd ? ir[15:11] : ir[20:16];
    assign rf_wdata = ctrl.mem_read ? mdr : result;

    // pc on fetch, effective address on load/store
    assign adr = (state == mips_pkg::st_mem) ? result : pc;
    assign dat = opb;

    assign v0_is_ten      = (v0 == 32'd10);
    assign operands_equal = (opa == opb);

endmodule

`default_nettype wire

/* src/mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    output wire  mips_pkg::wb_req_t  wb_req,
    input  wire  mips_pkg::wb_rsp_t  wb_rsp,
    output wire                      halted,
    output wire  mips_pkg::word_t    retired
);

    wire mips_pkg::ctrl_t     ctrl;
    wire mips_pkg::state_t    state;
    wire mips_pkg::word_t     ir, v0, rf_rdata_a, rf_rdata_b, rf_wdata;
    wire mips_pkg::word_t     alu_a, alu_b, alu_result;
    wire mips_pkg::reg_addr_t rf_raddr_a, rf_raddr_b, rf_waddr;
    wire mips_pkg::alu_op_t   alu_op;
    wire                      rf_we, v0_is_ten, operands_equal, retire, halt;

    mips_control u_control (
        .clk(clk), .rst_n(rst_n), .ir(ir), .v0_is_ten(v0_is_ten),
        .operands_equal(operands_equal), .ack(wb_rsp.ack), .ctrl(ctrl), .state(state),
        .cyc(wb_req.cyc), .stb(wb_req.stb), .we(wb_req.we), .retire(retire), .halt(halt)
    );

    mips_datapath #(
        .reset_pc(reset_pc)
    ) u_datapath (
        .clk(clk), .rst_n(rst_n), .state(state), .ctrl(ctrl),
        .bus_rdata(wb_rsp.dat), .ack(wb_rsp.ack),
        .rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b), .v0(v0), .alu_result(alu_result),
        .ir(ir), .adr(wb_req.adr), .dat(wb_req.dat),
        .rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
        .v0_is_ten(v0_is_ten), .operands_equal(operands_equal)
    );

    regfile u_regfile (
        .clk(clk), .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .v0(v0)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .y(alu_result)
    );

    retire_counter u_retire_counter (
        .clk(clk), .rst_n(rst_n), .retire(retire), .halt(halt),
        .retired(retired), .halted(halted)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* dv/tb_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;

    // two passes of both programs, at most 11 cycles per instruction
    localparam int instr_total = 2 * (46 + 20);
    localparam int cycle_limit = 2 * (instr_total * 11 + 4 * 20);

    logic              clk;
    logic              rst_n = 1'b0;
    mips_pkg::wb_req_t wb_req;
    mips_pkg::wb_rsp_t wb_rsp = '0;
    logic              halted;
    mips_pkg::word_t   retired;

    mips_pkg::word_t mem [1024];
    mips_pkg::word_t model_mem [1024];
    mips_pkg::word_t sum_data [8];
    logic [63:0]     exp_writes [$];
    logic [63:0]     dut_writes [$];
    int              seed = 39288;
    int              errors = 0;
    int              cycles = 0;

    tb_clock #(.period_ns(40.0)) u_clock (.clk(clk));

    mips_top #(.reset_pc('0)) UUT (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .halted(halted), .retired(retired)
    );

    function automatic mips_pkg::word_t rtype_word(input int rs, input int rt, input int rd,
                                                   input logic [5:0] fn);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic mips_pkg::word_t itype_word(input logic [5:0] op, input int rs,
                                                   input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // instruction-set model, runs on model_mem and queues every store
    function automatic int run_model();
        mips_pkg::word_t r [32];
        mips_pkg::word_t pc, npc, ins, imm, ea;
        logic [4:0]      rs, rt, rd;
        int              count;
        int              i;
        bit              stop;
        for (i = 0; i < 32; i++) r[i] = '0;
        pc = '0;
        count = 0;
        stop = 1'b0;
        while (!stop && count < 1000) begin
            ins = model_mem[pc[11:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea = r[rs] + imm;
            npc = pc + 32'd4;
            case (ins[31:26])
                op_special: begin
                    case (ins[5:0])
                        fn_addu: r[rd] = r[rs] + r[rt];
                        fn_subu: r[rd] = r[rs] - r[rt];
                        fn_and:  r[rd] = r[rs] & r[rt];
                        fn_or:   r[rd] = r[rs] | r[rt];
                        fn_slt:  r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
                        fn_syscall: stop = (r[2] == 32'd10);
                        default: ;
                    endcase
                end
                op_addiu: r[rt] = ea;
                op_lw:    r[rt] = model_mem[ea[11:2]];
                op_sw: begin
                    model_mem[ea[11:2]] = r[rt];
                    exp_writes.push_back({ea, r[rt]});
                end
                op_beq: if (r[rs] == r[rt]) npc = npc + (imm << 2);
                op_bne: if (r[rs] != r[rt]) npc = npc + (imm << 2);
                op_j:   npc = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            r[0] = '0;
            pc = npc;
            count++;
        end
        return count;
    endfunction

    task automatic load_program(input int prog);
        int i;
        for (i = 0; i < 1024; i++) mem[i] = 32'hc0de0000 ^ 32'(i);
        if (prog == 0) begin
            // sum of 8 words at 0x100, stored at 0x200
            mem[0]  = itype_word(op_addiu, 0, 8, 'h100);
            mem[1]  = itype_word(op_addiu, 0, 9, 8);
            mem[2]  = rtype_word(0, 0, 10, fn_addu);
            mem[3]  = itype_word(op_lw, 8, 11, 0);
            mem[4]  = rtype_word(10, 11, 10, fn_addu);
            mem[5]  = itype_word(op_addiu, 8, 8, 4);
            mem[6]  = itype_word(op_addiu, 9, 9, -1);
            mem[7]  = itype_word(op_bne, 9, 0, -5);
            mem[8]  = itype_word(op_sw, 0, 10, 'h200);
            mem[9]  = itype_word(op_addiu, 0, 2, 10);
            mem[10] = rtype_word(0, 0, 0, fn_syscall);
            for (i = 0; i < 8; i++) mem[64 + i] = sum_data[i];
        end else begin
            mem[0]  = itype_word(op_addiu, 0, 16, 37);
            mem[1]  = itype_word(op_addiu, 0, 17, -5);
            mem[2]  = rtype_word(16, 17, 8, fn_subu);
            mem[3]  = itype_word(op_sw, 0, 8, 'h200);
            mem[4]  = rtype_word(16, 17, 9, fn_and);
            mem[5]  = itype_word(op_sw, 0, 9, 'h204);
            mem[6]  = rtype_word(16, 17, 10, fn_or);
            mem[7]  = itype_word(op_sw, 0, 10, 'h208);
            mem[8]  = rtype_word(17, 16, 11, fn_slt);
            mem[9]  = itype_word(op_sw, 0, 11, 'h20c);
            mem[10] = rtype_word(16, 17, 12, fn_slt);
            mem[11] = itype_word(op_sw, 0, 12, 'h210);
            // not taken
            mem[12] = itype_word(op_beq, 16, 17, 1);
            mem[13] = itype_word(op_addiu, 0, 2, 3);
            // $v0 is 3 here, must not halt
            mem[14] = rtype_word(0, 0, 0, fn_syscall);
            mem[15] = itype_word(op_beq, 11, 11, 1);
            mem[16] = itype_word(op_sw, 0, 16, 'h214);
            mem[17] = {op_j, 26'd19};
            mem[18] = itype_word(op_sw, 0, 17, 'h218);
            mem[19] = itype_word(op_sw, 0, 2, 'h21c);
            mem[20] = itype_word(op_addiu, 0, 2, 10);
            mem[21] = rtype_word(0, 0, 0, fn_syscall);
        end
    endtask

    task automatic reset_dut();
        rst_n <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (wb_req.cyc !== 1'b0) begin
                $display("Mismatch wb_req.cyc: got %h expected 0 in reset", wb_req.cyc);
                errors++;
            end
            if (wb_req.stb !== 1'b0) begin
                $display("Mismatch wb_req.stb: got %h expected 0 in reset", wb_req.stb);
                errors++;
            end
            if (wb_req.we !== 1'b0) begin
                $display("Mismatch wb_req.we: got %h expected 0 in reset", wb_req.we);
                errors++;
            end
            if (halted !== 1'b0) begin
                $display("Mismatch halted: got %h expected 0 in reset", halted);
                errors++;
            end
            if (retired !== '0) begin
                $display("Mismatch retired: got %h expected 00000000 in reset", retired);
                errors++;
            end
        end
        rst_n <= 1'b1;
        @(negedge clk);
        if (wb_req.adr !== '0) begin
            $display("Mismatch wb_req.adr: got %h expected 00000000 on first fetch", wb_req.adr);
            errors++;
        end
        if (wb_req.we !== 1'b0) begin
            $display("Mismatch wb_req.we: got %h expected 0 on first fetch", wb_req.we);
            errors++;
        end
    endtask

    task automatic run_program(input int prog);
        int expected;
        int i;
        load_program(prog);
        model_mem = mem;
        exp_writes.delete();
        dut_writes.delete();
        expected = run_model();
        reset_dut();
        while (halted !== 1'b1) @(negedge clk);
        // stay a few cycles to watch for bus activity after halt
        repeat (6) @(negedge clk);
        if (retired !== 32'(expected)) begin
            $display("Mismatch retired: got %h expected %h", retired, 32'(expected));
            errors++;
        end
        if (exp_writes.size() != 0) begin
            $display("program %0d ended with %0d stores missing", prog, exp_writes.size());
            errors++;
        end
        for (i = 0; i < 1024; i++) begin
            if (mem[i] !== model_mem[i]) begin
                $display("Mismatch mem[%h]: got %h expected %h", i, mem[i], model_mem[i]);
                errors++;
            end
        end
    endtask

    // memory slave, 0 to 3 wait states per transfer
    always @(negedge clk) begin : wb_slave
        int waits;
        bit busy;
        if (!rst_n) begin
            wb_rsp <= '0;
            busy = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy = 1'b1;
                waits = $unsigned($random(seed)) % 4;
            end
            if (waits == 0) begin
                busy = 1'b0;
                if (wb_req.adr[31:12] != '0 || wb_req.adr[1:0] != 2'b00) begin
                    $display("bus access outside the memory at address %h", wb_req.adr);
                    errors++;
                end
                if (wb_req.we) begin
                    mem[wb_req.adr[11:2]] = wb_req.dat;
                    dut_writes.push_back({wb_req.adr, wb_req.dat});
                end
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[wb_req.adr[11:2]];
            end else begin
                waits--;
            end
        end
    end

    always @(negedge clk) begin : compare
        logic [63:0] got;
        logic [63:0] want;
        logic        was_halted;
        while (dut_writes.size() > 0) begin
            got = dut_writes.pop_front();
            if (exp_writes.size() == 0) begin
                $display("unexpected store of %h to address %h", got[31:0], got[63:32]);
                errors++;
            end else begin
                want = exp_writes.pop_front();
                if (got[63:32] !== want[63:32]) begin
                    $display("Mismatch wb_req.adr: got %h expected %h", got[63:32], want[63:32]);
                    errors++;
                end
                if (got[31:0] !== want[31:0]) begin
                    $display("Mismatch wb_req.dat: got %h expected %h", got[31:0], want[31:0]);
                    errors++;
                end
            end
        end
        if (!rst_n) begin
            was_halted = 1'b0;
        end else begin
            if (was_halted && halted !== 1'b1) begin
                $display("halted dropped without a reset");
                errors++;
            end
            if (was_halted && wb_req.cyc !== 1'b0) begin
                $display("bus cycle started after halt");
                errors++;
            end
            was_halted = (halted === 1'b1);
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, errors: %0d", cycles, errors);
        $display("test failed");
        $finish;
    end

    initial begin : main
        int pass;
        int prog;
        int i;
        @(negedge clk);
        for (i = 0; i < 8; i++) sum_data[i] = $random(seed);
        // second pass sees a different wait-state pattern
        for (pass = 0; pass < 2; pass++) begin
            for (prog = 0; prog < 2; prog++) begin
                run_program(prog);
            end
        end
        $display("run finished after %0d cycles, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/mips_pkg.sv
src/alu.sv
src/regfile.sv
src/retire_counter.sv
src/mips_control.sv
src/mips_datapath.sv
src/mips_top.sv
dv/tb_clock.sv
dv/tb_mips.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal
TOP      ?= tb_mips
FILELIST ?= src.f
OBJDIR   ?= obj_dir

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJDIR)
